// ==== hw/fill_cord_cfg.sv ====
////////////////////
// map registers for the lce coordinate map.
// read-back is combinational on cfg_addr_i. x_bits must stay at 2 or below.
////////////////////

`timescale 1ns/100ps
`default_nettype none

module fill_cord_cfg (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       cfg_w_v_i,
  input  logic [1:0]                 cfg_addr_i,
  input  logic [3:0]                 cfg_data_i,
  output logic [3:0]                 cfg_r_data_o,
  output noc_pkg::fill_cord_cfg_s    cord_cfg_o
);

  logic [noc_pkg::noc_cord_dim_width_lp-1:0] x_origin_r;
  logic [noc_pkg::noc_cord_dim_width_lp-1:0] y_origin_r;
  logic [noc_pkg::cord_x_bits_width_lp-1:0]  x_bits_r;

  ////////////////////
  // register writes.
  ////////////////////
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      x_origin_r <= noc_pkg::x_origin_rst_lp;
      y_origin_r <= noc_pkg::y_origin_rst_lp;
      x_bits_r   <= noc_pkg::x_bits_rst_lp;
    end else if (cfg_w_v_i) begin
      case (cfg_addr_i)
        noc_pkg::cfg_addr_x_origin_lp: x_origin_r <= cfg_data_i;
        noc_pkg::cfg_addr_y_origin_lp: y_origin_r <= cfg_data_i;
        noc_pkg::cfg_addr_x_bits_lp:   x_bits_r   <= cfg_data_i[1:0];
        default: begin
        end   // unmapped, dropped.
      endcase
    end
  end

  // read-back mux.
  always_comb begin
    case (cfg_addr_i)
      noc_pkg::cfg_addr_x_origin_lp: cfg_r_data_o = x_origin_r;
      noc_pkg::cfg_addr_y_origin_lp: cfg_r_data_o = y_origin_r;
      noc_pkg::cfg_addr_x_bits_lp:   cfg_r_data_o = {2'b00, x_bits_r};
      default:                       cfg_r_data_o = 4'd0;
    endcase
  end

  assign cord_cfg_o.x_origin = x_origin_r;
  assign cord_cfg_o.y_origin = y_origin_r;
  assign cord_cfg_o.x_bits   = x_bits_r;

  // a wider row would push core bits past the x field of the map.
  a_x_bits_range: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (cfg_w_v_i && cfg_addr_i == noc_pkg::cfg_addr_x_bits_lp)
      |-> cfg_data_i <= 4'(noc_pkg::cord_x_bits_max_lp)
  );

endmodule

`default_nettype wire

// ==== hw/fill_msg_pkg.sv ====
////////////////////
// fill message fields as the coherence engine drives them.
// size codes 0 to 6 only. code 7 (128 bytes) has no meaning here.
////////////////////

`default_nettype none

package fill_msg_pkg;

  localparam int lce_id_width_lp      = 4;
  localparam int paddr_width_lp       = 40;
  localparam int fill_way_width_lp    = 3;
  localparam int fill_state_width_lp  = 3;
  localparam int fill_block_width_lp  = 512;   // one full cache block.

  ////////////////////
  // message types.
  ////////////////////
  typedef enum logic [1:0] {
    e_fill_st_wakeup = 2'd0,   // no data.
    e_fill_uc_done   = 2'd1,   // no data.
    e_fill_data      = 2'd2,
    e_fill_uc_data   = 2'd3
  } fill_msg_type_e;

  // data size in bytes is 2**code.
  typedef enum logic [2:0] {
    e_fill_size_1  = 3'd0,
    e_fill_size_2  = 3'd1,
    e_fill_size_4  = 3'd2,
    e_fill_size_8  = 3'd3,
    e_fill_size_16 = 3'd4,
    e_fill_size_32 = 3'd5,
    e_fill_size_64 = 3'd6
  } fill_msg_size_e;

  ////////////////////
  // header, msb first. 55 bits in all.
  ////////////////////
  typedef struct packed {
    logic [fill_state_width_lp-1:0] state;
    logic [fill_way_width_lp-1:0]   way;
    logic [lce_id_width_lp-1:0]     dst_id;
    logic [paddr_width_lp-1:0]      addr;
    fill_msg_size_e                 size;
    fill_msg_type_e                 msg_type;   // lowest bits.
  } fill_header_s;

endpackage

`default_nettype wire

// ==== hw/fill_noc_top.sv ====
////////////////////
// fill messages in, wormhole flits out on one link.
// no credits. the link stalls by dropping link_ready_i.
////////////////////

`timescale 1ns/100ps
`default_nettype none

module fill_noc_top (
  input  logic                                      clk_i,
  input  logic                                      rst_i,
  // config port.
  input  logic                                      cfg_w_v_i,
  input  logic [1:0]                                cfg_addr_i,
  input  logic [3:0]                                cfg_data_i,
  output logic [3:0]                                cfg_r_data_o,
  // fill side.
  input  logic                                      fill_v_i,
  input  fill_msg_pkg::fill_header_s                fill_header_i,
  input  logic [fill_msg_pkg::fill_block_width_lp-1:0] fill_data_i,
  output logic                                      busy_o,
  // link side.
  output noc_pkg::noc_flit_u                        flit_o,
  output logic                                      flit_v_o,
  input  logic                                      link_ready_i
);

  noc_pkg::fill_cord_cfg_s  cord_cfg_li;
  noc_pkg::fill_wh_header_s wh_header_li;

  fill_cord_cfg i_fill_cord_cfg (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .cfg_w_v_i    (cfg_w_v_i),
    .cfg_addr_i   (cfg_addr_i),
    .cfg_data_i   (cfg_data_i),
    .cfg_r_data_o (cfg_r_data_o),
    .cord_cfg_o   (cord_cfg_li)
  );

  fill_wh_encode i_fill_wh_encode (
    .fill_header_i (fill_header_i),
    .cord_cfg_i    (cord_cfg_li),
    .wh_header_o   (wh_header_li)
  );

  fill_wh_serializer i_fill_wh_serializer (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .fill_v_i     (fill_v_i),
    .wh_header_i  (wh_header_li),
    .fill_data_i  (fill_data_i),
    .busy_o       (busy_o),
    .flit_o       (flit_o),
    .flit_v_o     (flit_v_o),
    .link_ready_i (link_ready_i)
  );

endmodule

`default_nettype wire

// ==== hw/fill_wh_encode.sv ====
////////////////////
// fill header to wormhole header. purely combinational.
// header is padded to 128 bits and data follows directly.
// size code 7 gives len 0.
////////////////////

`timescale 1ns/100ps
`default_nettype none

module fill_wh_encode (
  input  fill_msg_pkg::fill_header_s  fill_header_i,
  input  noc_pkg::fill_cord_cfg_s     cord_cfg_i,
  output noc_pkg::fill_wh_header_s    wh_header_o
);

  // flits for header plus data_bits, rounded up, minus one.
  function automatic logic [noc_pkg::noc_len_width_lp-1:0] len_for_bits(input int data_bits);
    int flits;
    flits = (noc_pkg::wh_header_width_lp + data_bits + noc_pkg::noc_flit_width_lp - 1)
            / noc_pkg::noc_flit_width_lp;
    return flits[noc_pkg::noc_len_width_lp-1:0] - 4'd1;
  endfunction

  ////////////////////
  // packet lengths.
  ////////////////////
  localparam logic [noc_pkg::noc_len_width_lp-1:0] len_no_data_lp = len_for_bits(0);
  localparam logic [noc_pkg::noc_len_width_lp-1:0] len_data_1_lp  = len_for_bits(1*8);
  localparam logic [noc_pkg::noc_len_width_lp-1:0] len_data_2_lp  = len_for_bits(2*8);
  localparam logic [noc_pkg::noc_len_width_lp-1:0] len_data_4_lp  = len_for_bits(4*8);
  localparam logic [noc_pkg::noc_len_width_lp-1:0] len_data_8_lp  = len_for_bits(8*8);
  localparam logic [noc_pkg::noc_len_width_lp-1:0] len_data_16_lp = len_for_bits(16*8);
  localparam logic [noc_pkg::noc_len_width_lp-1:0] len_data_32_lp = len_for_bits(32*8);
  localparam logic [noc_pkg::noc_len_width_lp-1:0] len_data_64_lp = len_for_bits(64*8);

  logic [noc_pkg::noc_cord_width_lp-1:0] lce_cord_li;
  logic [noc_pkg::noc_cid_width_lp-1:0]  lce_cid_li;
  logic                                  has_data;

  lce_id_to_cord i_lce_id_to_cord (
    .lce_id_i   (fill_header_i.dst_id),
    .cord_cfg_i (cord_cfg_i),
    .lce_cord_o (lce_cord_li),
    .lce_cid_o  (lce_cid_li)
  );

  assign has_data = (fill_header_i.msg_type == fill_msg_pkg::e_fill_data)
                 || (fill_header_i.msg_type == fill_msg_pkg::e_fill_uc_data);

  always_comb begin
    wh_header_o              = '0;   // pad and len default to zero.
    wh_header_o.msg_hdr      = fill_header_i;
    wh_header_o.rtr_hdr.cord = lce_cord_li;
    wh_header_o.rtr_hdr.cid  = lce_cid_li;

    if (has_data) begin
      unique case (fill_header_i.size)
        fill_msg_pkg::e_fill_size_1:  wh_header_o.rtr_hdr.len = len_data_1_lp;
        fill_msg_pkg::e_fill_size_2:  wh_header_o.rtr_hdr.len = len_data_2_lp;
        fill_msg_pkg::e_fill_size_4:  wh_header_o.rtr_hdr.len = len_data_4_lp;
        fill_msg_pkg::e_fill_size_8:  wh_header_o.rtr_hdr.len = len_data_8_lp;
        fill_msg_pkg::e_fill_size_16: wh_header_o.rtr_hdr.len = len_data_16_lp;
        fill_msg_pkg::e_fill_size_32: wh_header_o.rtr_hdr.len = len_data_32_lp;
        fill_msg_pkg::e_fill_size_64: wh_header_o.rtr_hdr.len = len_data_64_lp;
        default: begin
        end   // 128 bytes unsupported.
      endcase
    end else begin
      wh_header_o.rtr_hdr.len = len_no_data_lp;   // header only.
    end
  end

  // a data fill beyond 64 bytes would go out as a bare header flit.
  always_comb begin
    if (!$isunknown(fill_header_i.msg_type) && !$isunknown(fill_header_i.size) && has_data) begin
      a_data_size: assert final (fill_header_i.size <= fill_msg_pkg::e_fill_size_64);
    end
  end

endmodule

`default_nettype wire

// ==== hw/fill_wh_serializer.sv ====
////////////////////
// one-packet holding register, shifted out a flit per take.
// fill_v_i must stay low while busy_o is high.
// busy_o depends on link_ready_i in the last flit's cycle.
////////////////////

`timescale 1ns/100ps
`default_nettype none

module fill_wh_serializer (
  input  logic                                      clk_i,
  input  logic                                      rst_i,
  input  logic                                      fill_v_i,
  input  noc_pkg::fill_wh_header_s                  wh_header_i,
  input  logic [fill_msg_pkg::fill_block_width_lp-1:0] fill_data_i,
  output logic                                      busy_o,
  output noc_pkg::noc_flit_u                        flit_o,
  output logic                                      flit_v_o,
  input  logic                                      link_ready_i
);

  logic [noc_pkg::noc_packet_width_lp-1:0] pkt_r;
  logic [noc_pkg::noc_packet_width_lp-1:0] pkt_li;
  logic [noc_pkg::noc_len_width_lp-1:0]    cnt_r;   // flits left after the current one.
  logic                                    flit_v_r;
  noc_pkg::noc_flit_u                      head_flit_li;
  logic                                    take;
  logic                                    last_take;
  logic                                    accept;

  assign pkt_li           = {fill_data_i, wh_header_i};   // header in the low flits.
  assign head_flit_li.raw = pkt_li[noc_pkg::noc_flit_width_lp-1:0];

  ////////////////////
  // handshake.
  ////////////////////
  assign take      = flit_v_r & link_ready_i;
  assign last_take = take & (cnt_r == '0);
  assign busy_o    = flit_v_r & ~last_take;   // frees up on the final take.
  assign accept    = fill_v_i & ~busy_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      flit_v_r <= 1'b0;
      cnt_r    <= '0;
    end else if (accept) begin
      flit_v_r <= 1'b1;
      cnt_r    <= head_flit_li.hdr.rtr.len;
    end else if (take) begin
      flit_v_r <= ~last_take;
      cnt_r    <= cnt_r - 4'd1;   // wraps on the last take, unused then.
    end
  end

  // payload shifter.
  always_ff @(posedge clk_i) begin
    if (accept) begin
      pkt_r <= pkt_li;
    end else if (take) begin
      pkt_r <= pkt_r >> noc_pkg::noc_flit_width_lp;
    end
  end

  assign flit_o.raw = pkt_r[noc_pkg::noc_flit_width_lp-1:0];
  assign flit_v_o   = flit_v_r;

  ////////////////////
  // protocol checks.
  ////////////////////
  // a strobe while busy would be dropped and the packet lost.
  a_no_strobe_busy: assert property (
    @(posedge clk_i) disable iff (rst_i)
    fill_v_i |-> !busy_o
  );

  // a stalled flit holds until the link takes it.
  a_flit_hold: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (flit_v_o && !link_ready_i) |=> (flit_v_o && $stable(flit_o))
  );

endmodule

`default_nettype wire

// ==== hw/lce_id_to_cord.sv ====
////////////////////
// lce id to router coordinate and channel.
// two lces per core. sums wrap at 16 with no range check.
////////////////////

`timescale 1ns/100ps
`default_nettype none

module lce_id_to_cord (
  input  logic [fill_msg_pkg::lce_id_width_lp-1:0]  lce_id_i,
  input  noc_pkg::fill_cord_cfg_s                   cord_cfg_i,
  output logic [noc_pkg::noc_cord_width_lp-1:0]     lce_cord_o,
  output logic [noc_pkg::noc_cid_width_lp-1:0]      lce_cid_o
);

  logic [noc_pkg::noc_cord_dim_width_lp-1:0] core;
  logic [noc_pkg::noc_cord_dim_width_lp-1:0] x_mask;
  logic [noc_pkg::noc_cord_dim_width_lp-1:0] x_off;
  logic [noc_pkg::noc_cord_dim_width_lp-1:0] y_off;
  logic [noc_pkg::noc_cord_dim_width_lp-1:0] x;
  logic [noc_pkg::noc_cord_dim_width_lp-1:0] y;

  assign core = lce_id_i >> 1;   // drop the channel bit.

  // low x_bits of the core pick the column, the rest the row.
  assign x_mask = (4'd1 << cord_cfg_i.x_bits) - 4'd1;
  assign x_off  = core & x_mask;
  assign y_off  = core >> cord_cfg_i.x_bits;

  assign x = cord_cfg_i.x_origin + x_off;   // mod 16.
  assign y = cord_cfg_i.y_origin + y_off;

  assign lce_cord_o = {y, x};
  assign lce_cid_o  = {1'b0, lce_id_i[0]};

endmodule

`default_nettype wire

// ==== hw/noc_pkg.sv ====
////////////////////
// coherence network widths and packet layout.
// compile after fill_msg_pkg. a packet is at most 10 flits of 64 bits.
////////////////////

`default_nettype none

package noc_pkg;

  localparam int noc_flit_width_lp      = 64;
  localparam int noc_cord_width_lp      = 8;    // {y, x}.
  localparam int noc_cord_dim_width_lp  = 4;
  localparam int noc_len_width_lp       = 4;
  localparam int noc_cid_width_lp       = 2;
  localparam int wh_header_width_lp     = 128;  // two whole flits.
  localparam int max_packet_flits_lp    = 10;
  localparam int noc_packet_width_lp    = max_packet_flits_lp * noc_flit_width_lp;

  ////////////////////
  // router header, msb first.
  ////////////////////
  typedef struct packed {
    logic [noc_cid_width_lp-1:0]  cid;
    logic [noc_len_width_lp-1:0]  len;    // flits after the first.
    logic [noc_cord_width_lp-1:0] cord;
  } noc_rtr_hdr_s;

  localparam int noc_rtr_hdr_width_lp = $bits(noc_rtr_hdr_s);
  localparam int wh_pad_width_lp =
    wh_header_width_lp - noc_rtr_hdr_width_lp - $bits(fill_msg_pkg::fill_header_s);

  typedef struct packed {
    logic [wh_pad_width_lp-1:0]  pad;
    fill_msg_pkg::fill_header_s  msg_hdr;
    noc_rtr_hdr_s                rtr_hdr;
  } fill_wh_header_s;

  // one flit. the first flit of a packet is read through hdr.
  typedef union packed {
    logic [noc_flit_width_lp-1:0] raw;
    struct packed {
      logic [noc_flit_width_lp-noc_rtr_hdr_width_lp-1:0] rest;
      noc_rtr_hdr_s                                      rtr;
    } hdr;
  } noc_flit_u;

  ////////////////////
  // coordinate map config.
  ////////////////////
  localparam int cord_x_bits_width_lp = 2;
  localparam int cord_x_bits_max_lp   = 2;   // row of at most 4 cores.

  typedef struct packed {
    logic [noc_cord_dim_width_lp-1:0] x_origin;
    logic [noc_cord_dim_width_lp-1:0] y_origin;
    logic [cord_x_bits_width_lp-1:0]  x_bits;
  } fill_cord_cfg_s;

  localparam logic [1:0] cfg_addr_x_origin_lp = 2'd0;
  localparam logic [1:0] cfg_addr_y_origin_lp = 2'd1;
  localparam logic [1:0] cfg_addr_x_bits_lp   = 2'd2;

  localparam logic [noc_cord_dim_width_lp-1:0] x_origin_rst_lp = 4'd0;
  localparam logic [noc_cord_dim_width_lp-1:0] y_origin_rst_lp = 4'd1;
  localparam logic [cord_x_bits_width_lp-1:0]  x_bits_rst_lp   = 2'd1;

endpackage

`default_nettype wire

// ==== sources.f ====
hw/fill_msg_pkg.sv
hw/noc_pkg.sv
hw/fill_cord_cfg.sv
hw/lce_id_to_cord.sv
hw/fill_wh_encode.sv
hw/fill_wh_serializer.sv
hw/fill_noc_top.sv
verif/fill_noc_tb.sv

// ==== verif/fill_noc_tb.sv ====
////////////////////
// table-driven testbench for fill_noc_top.
// pass 0 runs with link always ready, pass 1 with random stalls.
// stops at the first mismatch.
////////////////////

`timescale 1ns/100ps
`default_nettype none

module fill_noc_tb;

  localparam int timeout_cycles_lp = 100;

  typedef struct packed {
    logic [3:0]  x_origin;
    logic [3:0]  y_origin;
    logic [1:0]  x_bits;
    logic [1:0]  msg_type;
    logic [2:0]  size;
    logic [3:0]  dst_id;
    logic [39:0] addr;
    logic [15:0] seed;
    logic [3:0]  exp_len;
    logic [7:0]  exp_cord;
  } fill_case_s;

  typedef struct packed {
    logic [63:0] raw;
    logic        head;   // first flit of a packet.
    logic [3:0]  len;
    logic [7:0]  cord;
    logic [1:0]  cid;
  } exp_flit_s;

  logic                       clk_i;
  logic                       rst_i;
  logic                       cfg_w_v_i;
  logic [1:0]                 cfg_addr_i;
  logic [3:0]                 cfg_data_i;
  logic [3:0]                 cfg_r_data_o;
  logic                       fill_v_i;
  fill_msg_pkg::fill_header_s fill_header_i;
  logic [511:0]               fill_data_i;
  logic                       busy_o;
  noc_pkg::noc_flit_u         flit_o;
  logic                       flit_v_o;
  logic                       link_ready_i;

  fill_case_s              tbl[$];
  exp_flit_s               exp_q[$];
  noc_pkg::fill_cord_cfg_s cur_cfg;   // what the registers should hold.
  logic                    cfg_check_pending;
  logic [3:0]              cfg_check_value;
  int                      idle_cycles;
  int                      idx;
  int                      pass;
  fill_case_s              cur_case;

  fill_noc_top i_fill_noc_top (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .cfg_w_v_i     (cfg_w_v_i),
    .cfg_addr_i    (cfg_addr_i),
    .cfg_data_i    (cfg_data_i),
    .cfg_r_data_o  (cfg_r_data_o),
    .fill_v_i      (fill_v_i),
    .fill_header_i (fill_header_i),
    .fill_data_i   (fill_data_i),
    .busy_o        (busy_o),
    .flit_o        (flit_o),
    .flit_v_o      (flit_v_o),
    .link_ready_i  (link_ready_i)
  );

  always #5 clk_i = ~clk_i;

  ////////////////////
  // helpers.
  ////////////////////
  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    string line;
    if (got !== exp) begin
      line = $sformatf("** Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      abort_run(line);
    end
  endtask

  task automatic add_case(input logic [3:0] xo, input logic [3:0] yo, input logic [1:0] xb,
                          input logic [1:0] mtype, input logic [2:0] size,
                          input logic [3:0] dst, input logic [39:0] addr,
                          input logic [15:0] seed, input logic [3:0] len,
                          input logic [7:0] cord);
    fill_case_s c;
    c.x_origin = xo;
    c.y_origin = yo;
    c.x_bits   = xb;
    c.msg_type = mtype;
    c.size     = size;
    c.dst_id   = dst;
    c.addr     = addr;
    c.seed     = seed;
    c.exp_len  = len;
    c.exp_cord = cord;
    tbl.push_back(c);
  endtask

  // every word differs, so a misplaced flit shows up.
  function automatic logic [511:0] make_data(input logic [15:0] seed);
    logic [511:0] d;
    int i;
    for (i = 0; i < 16; i++) begin
      d[32*i +: 32] = {seed ^ 16'(i * 16'h2b17), 16'(i)};
    end
    return d;
  endfunction

  task automatic write_cfg(input logic [1:0] addr, input logic [3:0] data);
    cfg_w_v_i         = 1'b1;
    cfg_addr_i        = addr;
    cfg_data_i        = data;
    cfg_check_pending = 1'b1;   // read back next cycle.
    cfg_check_value   = data;
    idle_cycles       = 0;
  endtask

  // drive one fill and queue its model flits.
  task automatic send_fill(input fill_case_s c);
    fill_msg_pkg::fill_header_s hdr;
    noc_pkg::fill_wh_header_s   wh;
    logic [511:0]               data;
    logic [639:0]               pkt;
    exp_flit_s                  ef;
    int                         k;
    hdr          = '0;
    hdr.msg_type = fill_msg_pkg::fill_msg_type_e'(c.msg_type);
    hdr.size     = fill_msg_pkg::fill_msg_size_e'(c.size);
    hdr.addr     = c.addr;
    hdr.dst_id   = c.dst_id;
    hdr.way      = c.seed[2:0];
    hdr.state    = c.seed[5:3];
    data         = make_data(c.seed);
    wh              = '0;
    wh.msg_hdr      = hdr;
    wh.rtr_hdr.cord = c.exp_cord;
    wh.rtr_hdr.len  = c.exp_len;
    wh.rtr_hdr.cid  = {1'b0, c.dst_id[0]};
    pkt = {data, wh};   // data right after the 128-bit header.
    for (k = 0; k <= c.exp_len; k++) begin
      ef.raw  = pkt[64*k +: 64];
      ef.head = (k == 0);
      ef.len  = c.exp_len;
      ef.cord = c.exp_cord;
      ef.cid  = {1'b0, c.dst_id[0]};
      exp_q.push_back(ef);
    end
    fill_header_i = hdr;
    fill_data_i   = data;
    fill_v_i      = 1'b1;
    idle_cycles   = 0;
  endtask

  task automatic check_taken_flit();
    exp_flit_s ef;
    if (exp_q.size() == 0) begin
      abort_run("a flit was taken while no packet was outstanding");
    end
    ef = exp_q.pop_front();
    if (ef.head) begin
      check_value("flit_o.hdr.rtr.cord", flit_o.hdr.rtr.cord, ef.cord);
      check_value("flit_o.hdr.rtr.len", flit_o.hdr.rtr.len, ef.len);
      check_value("flit_o.hdr.rtr.cid", flit_o.hdr.rtr.cid, ef.cid);
    end
    check_value("flit_o", flit_o.raw, ef.raw);
  endtask

  ////////////////////
  // stimulus.
  ////////////////////
  initial begin
    void'($urandom(16941));
    clk_i             = 1'b0;
    rst_i             = 1'b1;
    cfg_w_v_i         = 1'b0;
    cfg_addr_i        = 2'd0;
    cfg_data_i        = 4'd0;
    fill_v_i          = 1'b0;
    fill_header_i     = '0;
    fill_data_i       = '0;
    link_ready_i      = 1'b0;
    cfg_check_pending = 1'b0;
    cfg_check_value   = 4'd0;
    idle_cycles       = 0;

    // x_org y_org x_bits | type size dst addr seed | len cord.
    add_case(4'd0, 4'd1, 2'd1, 2'd0, 3'd0, 4'd5, 40'h00_1234_5600, 16'h1a01, 4'd1, 8'h20);
    add_case(4'd0, 4'd1, 2'd1, 2'd1, 3'd3, 4'd2, 40'h80_0000_0040, 16'h2b02, 4'd1, 8'h11);
    add_case(4'd0, 4'd1, 2'd1, 2'd2, 3'd0, 4'd0, 40'h12_3456_7801, 16'h3c03, 4'd2, 8'h10);
    add_case(4'd0, 4'd1, 2'd1, 2'd3, 3'd1, 4'd3, 40'h12_3456_7802, 16'h4d04, 4'd2, 8'h11);
    add_case(4'd0, 4'd1, 2'd1, 2'd2, 3'd2, 4'd7, 40'h12_3456_7804, 16'h5e05, 4'd2, 8'h21);
    add_case(4'd0, 4'd1, 2'd1, 2'd3, 3'd3, 4'd6, 40'h12_3456_7808, 16'h6f06, 4'd2, 8'h21);
    add_case(4'd0, 4'd1, 2'd1, 2'd2, 3'd4, 4'd9, 40'hff_0000_1010, 16'h7a07, 4'd3, 8'h30);
    add_case(4'd0, 4'd1, 2'd1, 2'd3, 3'd5, 4'd12, 40'hff_0000_2020, 16'h8b08, 4'd5, 8'h40);
    add_case(4'd0, 4'd1, 2'd1, 2'd2, 3'd6, 4'd15, 40'hab_cdef_0040, 16'h9c09, 4'd9, 8'h41);
    // new map values.
    add_case(4'd3, 4'd2, 2'd2, 2'd2, 3'd6, 4'd11, 40'h01_0000_0080, 16'had0a, 4'd9, 8'h34);
    add_case(4'd3, 4'd2, 2'd2, 2'd0, 3'd0, 4'd14, 40'h01_0000_00c0, 16'hbe0b, 4'd1, 8'h36);
    add_case(4'd14, 4'd15, 2'd0, 2'd3, 3'd4, 4'd13, 40'h7f_ffff_fff0, 16'hcf0c, 4'd3, 8'h5e);
    add_case(4'd14, 4'd15, 2'd0, 2'd2, 3'd5, 4'd1, 40'h00_0000_0020, 16'hd00d, 4'd5, 8'hfe);
    add_case(4'd15, 4'd0, 2'd2, 2'd1, 3'd2, 4'd10, 40'h55_aa55_aa00, 16'he10e, 4'd1, 8'h10);
    add_case(4'd15, 4'd0, 2'd2, 2'd2, 3'd6, 4'd8, 40'h0f_0f0f_0f40, 16'hf20f, 4'd9, 8'h1f);

    repeat (10) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    // reset values.
    check_value("flit_v_o", flit_v_o, 1'b0);
    check_value("busy_o", busy_o, 1'b0);
    cur_cfg.x_origin = 4'd0;
    cur_cfg.y_origin = 4'd1;
    cur_cfg.x_bits   = 2'd1;
    cfg_addr_i = 2'd0;
    #1 check_value("cfg_r_data_o", cfg_r_data_o, 4'd0);
    cfg_addr_i = 2'd1;
    #1 check_value("cfg_r_data_o", cfg_r_data_o, 4'd1);
    cfg_addr_i = 2'd2;
    #1 check_value("cfg_r_data_o", cfg_r_data_o, 4'd1);
    cfg_addr_i = 2'd3;
    #1 check_value("cfg_r_data_o", cfg_r_data_o, 4'd0);   // unmapped.

    for (pass = 0; pass < 2; pass++) begin
      idx = 0;
      while (idx < tbl.size() || exp_q.size() != 0) begin
        @(posedge clk_i);
        #1;
        fill_v_i     = 1'b0;
        cfg_w_v_i    = 1'b0;
        link_ready_i = (pass == 0) ? 1'b1 : (($urandom % 3) != 0);
        #1;   // outputs settled.
        idle_cycles++;
        if (cfg_check_pending) begin
          check_value("cfg_r_data_o", cfg_r_data_o, cfg_check_value);
          cfg_check_pending = 1'b0;
        end
        // at most one packet in flight, so the queue holds just its flits.
        check_value("flit_v_o", flit_v_o, exp_q.size() != 0);
        check_value("busy_o", busy_o,
                    exp_q.size() > 1 || (exp_q.size() == 1 && !link_ready_i));
        if (flit_v_o && link_ready_i) begin
          check_taken_flit();
          idle_cycles = 0;
        end
        if (idx < tbl.size()) begin
          cur_case = tbl[idx];
          // one register per cycle, then the fill.
          if (cur_cfg.x_origin != cur_case.x_origin) begin
            write_cfg(2'd0, cur_case.x_origin);
            cur_cfg.x_origin = cur_case.x_origin;
          end else if (cur_cfg.y_origin != cur_case.y_origin) begin
            write_cfg(2'd1, cur_case.y_origin);
            cur_cfg.y_origin = cur_case.y_origin;
          end else if (cur_cfg.x_bits != cur_case.x_bits) begin
            write_cfg(2'd2, {2'b00, cur_case.x_bits});
            cur_cfg.x_bits = cur_case.x_bits;
          end else if (!busy_o) begin
            send_fill(cur_case);   // same cycle busy_o drops.
            idx++;
          end
        end
        if (idle_cycles > timeout_cycles_lp) begin
          abort_run("timeout waiting for a flit to be taken or busy_o to drop");
        end
      end
    end

    @(posedge clk_i);
    #2;
    check_value("flit_v_o", flit_v_o, 1'b0);
    check_value("busy_o", busy_o, 1'b0);
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire
